// ==== design/cpuPkg.sv ====
/*
 * Shared constants and types for the single-cycle CPU core.
 * Referenced by scoped name (cpuPkg::name) from every RTL file.
 */
`default_nettype none

package cpuPkg;

	// Datapath widths
	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;

	// Primary opcodes, bits [31:26]
	localparam logic [5:0] opReg  = 6'b000000;
	localparam logic [5:0] opLw   = 6'b100011;
	localparam logic [5:0] opSw   = 6'b101011;
	localparam logic [5:0] opJ    = 6'b000010;
	localparam logic [5:0] opBgt  = 6'b000111;
	localparam logic [5:0] opAddi = 6'b001000;

	// Function codes for register-type instructions, bits [5:0]
	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr  = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnJr  = 6'b001000;

	// ALU operations
	localparam logic [2:0] aluNop = 3'b000;
	localparam logic [2:0] aluAdd = 3'b001;
	localparam logic [2:0] aluSub = 3'b010;
	localparam logic [2:0] aluAnd = 3'b011;
	localparam logic [2:0] aluOr  = 3'b100;
	localparam logic [2:0] aluXor = 3'b101;
	localparam logic [2:0] aluSlt = 3'b110;
	localparam logic [2:0] aluSll = 3'b111;

	// Next-PC source
	localparam logic [1:0] pcSeq    = 2'b00;
	localparam logic [1:0] pcBranch = 2'b01;
	localparam logic [1:0] pcJump   = 2'b10;
	localparam logic [1:0] pcReg    = 2'b11;

	// One instruction word, seen in its three encodings
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iType;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] index;
		} jType;
	} instrT;

endpackage

`default_nettype wire

// ==== design/decode.sv ====
/*
 * Instruction decode for the single-cycle core.
 * Maps the fetched word and the ALU flags onto datapath control.
 */
`timescale 1ns/1ns
`default_nettype none

module decode (
	input  cpuPkg::instrT                   instr,
	input  logic                            aluNeg,
	input  logic                            aluZero,
	output logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	output logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	output logic [cpuPkg::regAddrWidth-1:0] wrAddr,
	output logic [2:0]                      aluCtl,
	output logic                            aluBSel,
	output logic                            shiftSel,
	output logic                            resultSel,
	output logic                            rfWriteEn,
	output logic                            dmemRead,
	output logic                            dmemWrite,
	output logic [1:0]                      pcSel
);

	// High when the destination is rd rather than rt
	logic regDest;

	assign rsAddr = instr.rType.rs;
	assign rtAddr = instr.rType.rt;
	assign wrAddr = regDest ? instr.rType.rd : instr.iType.rt;

	always_comb begin
		// Defaults describe a NOP, every case only overrides what it needs
		aluCtl    = cpuPkg::aluNop;
		aluBSel   = 1'b0;
		shiftSel  = 1'b0;
		resultSel = 1'b0;
		rfWriteEn = 1'b0;
		regDest   = 1'b0;
		dmemRead  = 1'b0;
		dmemWrite = 1'b0;
		pcSel     = cpuPkg::pcSeq;

		case (instr.jType.opcode)
			cpuPkg::opReg: begin
				regDest   = 1'b1;
				rfWriteEn = 1'b1;
				case (instr.rType.funct)
					cpuPkg::fnAdd: aluCtl = cpuPkg::aluAdd;
					cpuPkg::fnSub: aluCtl = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluCtl = cpuPkg::aluAnd;
					cpuPkg::fnOr:  aluCtl = cpuPkg::aluOr;
					cpuPkg::fnXor: aluCtl = cpuPkg::aluXor;
					cpuPkg::fnSlt: aluCtl = cpuPkg::aluSlt;
					cpuPkg::fnSll: begin
						aluCtl   = cpuPkg::aluSll;
						shiftSel = 1'b1;
					end
					cpuPkg::fnJr: begin
						rfWriteEn = 1'b0;
						pcSel     = cpuPkg::pcReg;
					end
					default: rfWriteEn = 1'b0;
				endcase
			end
			cpuPkg::opLw: begin
				aluCtl    = cpuPkg::aluAdd;
				aluBSel   = 1'b1;
				resultSel = 1'b1;
				rfWriteEn = 1'b1;
				dmemRead  = 1'b1;
			end
			cpuPkg::opSw: begin
				aluCtl    = cpuPkg::aluAdd;
				aluBSel   = 1'b1;
				dmemWrite = 1'b1;
			end
			cpuPkg::opJ: pcSel = cpuPkg::pcJump;
			cpuPkg::opBgt: begin
				// rs - rt is strictly positive when neither flag is set
				aluCtl = cpuPkg::aluSub;
				if (!aluNeg && !aluZero)
					pcSel = cpuPkg::pcBranch;
			end
			cpuPkg::opAddi: begin
				aluCtl    = cpuPkg::aluAdd;
				aluBSel   = 1'b1;
				rfWriteEn = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
/*
 * 32 x 32 register file, two asynchronous reads and one clocked write.
 * Register 0 is hardwired to zero.
 */
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	input  logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
	input  logic                            writeEn,
	input  logic [cpuPkg::dataWidth-1:0]    wrData,
	output logic [cpuPkg::dataWidth-1:0]    rsData,
	output logic [cpuPkg::dataWidth-1:0]    rtData
);

	localparam int numRegs = 2 ** cpuPkg::regAddrWidth;

	logic [cpuPkg::dataWidth-1:0] regs [numRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (writeEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Address 0 reads zero regardless of array contents
	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

// ==== design/alu.sv ====
/*
 * Integer ALU for the core.
 * Result plus negative and zero flags, the flags feed branch decode.
 */
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  logic [2:0]                   aluCtl,
	input  logic [cpuPkg::dataWidth-1:0] a,
	input  logic [cpuPkg::dataWidth-1:0] b,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic                         neg,
	output logic                         zero
);

	logic lessThan;

	// Signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluCtl)
			cpuPkg::aluAdd: result = a + b;
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr:  result = a | b;
			cpuPkg::aluXor: result = a ^ b;
			cpuPkg::aluSlt: result = {{(cpuPkg::dataWidth-1){1'b0}}, lessThan};
			// Shift amount is the low 5 bits of b
			cpuPkg::aluSll: result = a << b[4:0];
			cpuPkg::aluNop: result = '0;
			default:        result = '0;
		endcase
	end

	assign neg  = result[cpuPkg::dataWidth-1];
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/fetchUnit.sv ====
/*
 * Program counter and next-PC selection.
 * Picks pc+4, branch, jump or register target each cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [1:0]                   pcSel,
	input  logic [cpuPkg::dataWidth-1:0] immExt,
	input  logic [cpuPkg::dataWidth-1:0] regTarget,
	input  logic [25:0]                  jumpIndex,
	output logic [cpuPkg::dataWidth-1:0] pc
);

	logic [cpuPkg::dataWidth-1:0] pcPlus4;
	logic [cpuPkg::dataWidth-1:0] pcNext;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		case (pcSel)
			cpuPkg::pcBranch: pcNext = pcPlus4 + {immExt[cpuPkg::dataWidth-3:0], 2'b00};
			cpuPkg::pcJump:   pcNext = {pcPlus4[31:28], jumpIndex, 2'b00};
			cpuPkg::pcReg:    pcNext = regTarget;
			default:          pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else
			pc <= pcNext;
	end

	// Fetch stays word aligned, a jr to an odd address would break this
	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/cpuCore.sv ====
/*
 * Top of the single-cycle core: fetch, decode, register file and ALU.
 * Instruction and data memories sit outside and answer in the same cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module cpuCore (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] imemAddr,
	input  logic [31:0] imemData,
	output logic [31:0] dmemAddr,
	output logic [31:0] dmemWrData,
	output logic        dmemRead,
	output logic        dmemWrite,
	input  logic [31:0] dmemRdData
);

	cpuPkg::instrT instr;

	logic [cpuPkg::regAddrWidth-1:0] rsAddr, rtAddr, wrAddr;
	logic [2:0]                      aluCtl;
	logic                            aluBSel, shiftSel, resultSel, rfWriteEn;
	logic                            decRead, decWrite;
	logic [1:0]                      pcSel;
	logic [cpuPkg::dataWidth-1:0]    rsData, rtData, immExt;
	logic [cpuPkg::dataWidth-1:0]    aluA, aluB, aluResult, wrData;
	logic                            aluNeg, aluZero;

	assign instr  = imemData;
	assign immExt = {{(cpuPkg::dataWidth-16){instr.iType.imm[15]}}, instr.iType.imm};

	fetchUnit fetch0 (
		.clk(clk), .rst(rst), .pcSel(pcSel), .immExt(immExt),
		.regTarget(rsData), .jumpIndex(instr.jType.index), .pc(imemAddr)
	);

	decode decode0 (
		.instr(instr), .aluNeg(aluNeg), .aluZero(aluZero),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr), .aluCtl(aluCtl),
		.aluBSel(aluBSel), .shiftSel(shiftSel), .resultSel(resultSel),
		.rfWriteEn(rfWriteEn), .dmemRead(decRead), .dmemWrite(decWrite), .pcSel(pcSel)
	);

	regFile regFile0 (
		.clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr), .wrAddr(wrAddr),
		.writeEn(rfWriteEn), .wrData(wrData), .rsData(rsData), .rtData(rtData)
	);

	// sll shifts rt by shamt while everything else works on rs
	assign aluA = shiftSel ? rtData : rsData;
	assign aluB = shiftSel ? {{(cpuPkg::dataWidth-5){1'b0}}, instr.rType.shamt}
		: (aluBSel ? immExt : rtData);

	alu alu0 (
		.aluCtl(aluCtl), .a(aluA), .b(aluB),
		.result(aluResult), .neg(aluNeg), .zero(aluZero)
	);

	assign wrData = resultSel ? dmemRdData : aluResult;

	// Stores are held off while in reset
	assign dmemAddr   = aluResult;
	assign dmemWrData = rtData;
	assign dmemRead   = decRead;
	assign dmemWrite  = decWrite & ~rst;

	strobeExclusive: assert property (@(posedge clk) !(dmemRead && dmemWrite));

endmodule

`default_nettype wire

// ==== verif/cpuCoreTb.sv ====
/*
 * Directed testbench for the single-cycle core, with instruction and data memory models.
 * Each test loads a small program, runs it and checks memory words and fetch addresses.
 */
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb;

	localparam int clkPeriod = 8;
	localparam int memWords  = 256;
	// Per-test budgets in cycles including reset
	localparam int testCycles  = 31 + 11 + 13 + 29 + 13 + 16;
	localparam int slackCycles = 50;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] imemAddr, imemData, dmemAddr, dmemWrData, dmemRdData;
	logic        dmemRead, dmemWrite;

	logic [31:0] imem [memWords];
	logic [31:0] dmem [memWords];
	logic [31:0] pcTrace [64];
	logic [31:0] seed = 32'd65434;
	logic [31:0] readPc;
	int          checkCount = 0;
	int          errorCount = 0;
	int          testErrors, readCount, resetWrites;

	cpuCore dut0 (
		.clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemRead(dmemRead),
		.dmemWrite(dmemWrite), .dmemRdData(dmemRdData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Both memories answer in the same cycle
	assign imemData   = imem[imemAddr[9:2]];
	assign dmemRdData = dmem[dmemAddr[9:2]];

	// Stores land at the rising edge while dmemWrite is high
	always @(posedge clk) begin
		if (dmemWrite)
			dmem[dmemAddr[9:2]] = dmemWrData;
	end

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic logic [31:0] rInstr(input logic [4:0] rs, rt, rd, shamt,
		input logic [5:0] funct);
		return {cpuPkg::opReg, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Untouched data words keep a value tied to their index
	function automatic logic [31:0] fillWord(input int index);
		logic [7:0] i;
		i = index[7:0];
		return {8'h5a, i, ~i, i};
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			testErrors++;
			$display("Error in %s: expected %08h, actual %08h", testName, expected, actual);
		end
	endtask

	// All zero word is sll r0,r0,0 and acts as a NOP
	task automatic clearMemories();
		for (int i = 0; i < memWords; i++) begin
			imem[i] = 32'h0;
			dmem[i] = fillWord(i);
		end
	endtask

	// Memories are reloaded with rst already high so no stale store can land
	task automatic beginTest();
		@(negedge clk);
		rst = 1'b1;
		testErrors = 0;
		clearMemories();
	endtask

	task automatic releaseReset();
		resetWrites = 0;
		repeat (5) begin
			#2;
			if (dmemWrite)
				resetWrites++;
			@(negedge clk);
		end
		rst = 1'b0;
	endtask

	// Samples a quarter period after the falling edge where outputs have settled
	task automatic runCycles(input int n);
		readCount = 0;
		for (int k = 0; k < n; k++) begin
			#2;
			pcTrace[k] = imemAddr;
			if (dmemRead) begin
				readCount++;
				readPc = imemAddr;
			end
			@(negedge clk);
		end
	endtask

	task automatic endTest(input string testName);
		$display("%s finished with %0d errors", testName, testErrors);
	endtask

	task automatic testArithmetic();
		logic [31:0] r, a, b;
		logic [31:0] expected [7];
		logic [5:0]  fns [6];
		logic [4:0]  sh;
		beginTest();
		r = nextRand();
		a = (sext16(r[31:16]) << 16) + sext16(r[15:0]);
		imem[0] = iInstr(cpuPkg::opAddi, 0, 1, r[31:16]);
		imem[1] = rInstr(0, 1, 1, 16, cpuPkg::fnSll);
		imem[2] = iInstr(cpuPkg::opAddi, 1, 1, r[15:0]);
		r = nextRand();
		b = (sext16(r[31:16]) << 16) + sext16(r[15:0]);
		imem[3] = iInstr(cpuPkg::opAddi, 0, 2, r[31:16]);
		imem[4] = rInstr(0, 2, 2, 16, cpuPkg::fnSll);
		imem[5] = iInstr(cpuPkg::opAddi, 2, 2, r[15:0]);
		r = nextRand();
		sh = r[20:16];
		fns = '{cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOr,
			cpuPkg::fnXor, cpuPkg::fnSlt};
		for (int k = 0; k < 6; k++) begin
			imem[6 + 2 * k] = rInstr(1, 2, 4, 0, fns[k]);
			imem[7 + 2 * k] = iInstr(cpuPkg::opSw, 0, 4, 16'(4 * k));
		end
		imem[18] = rInstr(0, 1, 4, sh, cpuPkg::fnSll);
		imem[19] = iInstr(cpuPkg::opSw, 0, 4, 16'd24);
		expected = '{a + b, a - b, a & b, a | b, a ^ b,
			{31'b0, $signed(a) < $signed(b)}, a << sh};
		releaseReset();
		runCycles(24);
		for (int k = 0; k < 7; k++)
			checkValue("arithmetic", expected[k], dmem[k]);
		endTest("arithmetic");
	endtask

	task automatic testRoundTrip();
		logic [31:0] value;
		beginTest();
		value = nextRand();
		dmem[16] = value;
		imem[0] = iInstr(cpuPkg::opLw, 0, 5, 16'd64);
		imem[1] = iInstr(cpuPkg::opSw, 0, 5, 16'd128);
		releaseReset();
		runCycles(4);
		checkValue("round trip", value, dmem[32]);
		// dmemRead must be seen exactly once and only at the lw address
		checkValue("round trip", 32'd1, 32'(readCount));
		checkValue("round trip", 32'd0, readPc);
		endTest("round trip");
	endtask

	task automatic testImmediates();
		logic [31:0] r;
		logic [15:0] imm1, imm2;
		beginTest();
		r = nextRand();
		imm1 = r[15:0] | 16'h8000;
		imm2 = r[31:16] | 16'h8000;
		imem[0] = iInstr(cpuPkg::opAddi, 0, 1, imm1);
		imem[1] = iInstr(cpuPkg::opAddi, 1, 2, imm2);
		imem[2] = iInstr(cpuPkg::opAddi, 1, 0, 16'd5);
		imem[3] = iInstr(cpuPkg::opSw, 0, 1, 16'd0);
		imem[4] = iInstr(cpuPkg::opSw, 0, 2, 16'd4);
		imem[5] = iInstr(cpuPkg::opSw, 0, 0, 16'd8);
		releaseReset();
		runCycles(7);
		checkValue("immediates", sext16(imm1), dmem[0]);
		checkValue("immediates", sext16(imm1) + sext16(imm2), dmem[1]);
		checkValue("immediates", 32'd0, dmem[2]);
		endTest("immediates");
	endtask

	task automatic testBranch();
		int xs [5];
		int ys [5];
		beginTest();
		xs = '{5, 3, 4, -2, -7};
		ys = '{3, 5, 4, -7, -2};
		// A taken bgt with offset 1 skips the store right after it
		for (int k = 0; k < 5; k++) begin
			imem[4 * k]     = iInstr(cpuPkg::opAddi, 0, 1, 16'(xs[k]));
			imem[4 * k + 1] = iInstr(cpuPkg::opAddi, 0, 2, 16'(ys[k]));
			imem[4 * k + 2] = iInstr(cpuPkg::opBgt, 1, 2, 16'd1);
			imem[4 * k + 3] = iInstr(cpuPkg::opSw, 0, 1, 16'(4 * k));
		end
		releaseReset();
		runCycles(22);
		for (int k = 0; k < 5; k++)
			checkValue("bgt", (xs[k] > ys[k]) ? fillWord(k) : 32'(xs[k]), dmem[k]);
		endTest("bgt");
	endtask

	task automatic testControlFlow();
		beginTest();
		imem[0]  = iInstr(cpuPkg::opAddi, 0, 1, 16'd40);
		imem[1]  = {cpuPkg::opJ, 26'd6};
		imem[2]  = iInstr(cpuPkg::opSw, 0, 1, 16'd0);
		imem[6]  = rInstr(1, 0, 0, 0, cpuPkg::fnJr);
		imem[7]  = iInstr(cpuPkg::opSw, 0, 1, 16'd4);
		imem[10] = iInstr(cpuPkg::opSw, 0, 1, 16'd8);
		releaseReset();
		runCycles(6);
		checkValue("control flow", 32'd24, pcTrace[2]);
		checkValue("control flow", 32'd40, pcTrace[3]);
		checkValue("control flow", fillWord(0), dmem[0]);
		checkValue("control flow", fillWord(1), dmem[1]);
		checkValue("control flow", 32'd40, dmem[2]);
		endTest("control flow");
	endtask

	task automatic testReset();
		beginTest();
		for (int k = 0; k < 3; k++)
			imem[k] = iInstr(cpuPkg::opSw, 0, 0, 16'(4 * k));
		releaseReset();
		runCycles(3);
		// Reset again mid-program while decode asks for a store at pc 0
		rst = 1'b1;
		releaseReset();
		runCycles(1);
		checkValue("reset", 32'd0, 32'(resetWrites));
		checkValue("reset", 32'd0, pcTrace[0]);
		endTest("reset");
	endtask

	initial begin
		rst = 1'b1;
		clearMemories();
		testArithmetic();
		testRoundTrip();
		testImmediates();
		testBranch();
		testControlFlow();
		testReset();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#((testCycles + slackCycles) * clkPeriod);
		$display("Timeout: the tests did not finish within their cycle budget");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/cpuPkg.sv
design/decode.sv
design/regFile.sv
design/alu.sv
design/fetchUnit.sv
design/cpuCore.sv
verif/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuCoreTb -f filelist.f -o cpuCoreSim

output=$(./obj_dir/cpuCoreSim)
echo "$output"

if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1
